// File: design/riscv_isa_pkg.sv
// RV32I encoding constants and base types, imported by every decode-stage RTL file
package riscv_isa_pkg;

  // Data and address path width
  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // Major opcodes of the base integer subset, bits [6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_AUIPC  = 7'b001_0111,
    OPC_STORE  = 7'b010_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_JALR   = 7'b110_0111,
    OPC_JAL    = 7'b110_1111
  } opcode_e;

  // Register index fields
  localparam int unsigned RS1_MSB = 19;
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS2_MSB = 24;
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned RD_MSB  = 11;
  localparam int unsigned RD_LSB  = 7;

  // Function fields
  localparam int unsigned FUNCT3_MSB   = 14;
  localparam int unsigned FUNCT3_LSB   = 12;
  // Alternate-op bit (SUB, SRA, SRAI)
  localparam int unsigned FUNCT7_BIT30 = 30;

endpackage

// File: design/id_ctrl_pkg.sv
// Decode-stage control types shared by the decoder, operand muxes and ID/EX register
package id_ctrl_pkg;

  // ALU operations, including the branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Operand selects; NONE means the operand is unused by EX
  typedef enum logic [1:0] {OPA_NONE, OPA_REG, OPA_PC, OPA_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OPB_NONE, OPB_REG, OPB_IMM, OPB_PCINCR} op_b_sel_e;
  typedef enum logic [1:0] {OPC_NONE, OPC_REG, OPC_BCH} op_c_sel_e;

  // Immediate format
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  // Source of each register operand
  typedef enum logic [1:0] {
    FWD_RF,  // Register file read data
    FWD_EX,  // Result in EX
    FWD_WB   // Result in WB
  } fwd_sel_e;

  // Memory access width
  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;

endpackage

// File: design/id_ctrl_if.sv
// Decoded control bundle, driven by the decoder and read by the operand and pipeline logic
`timescale 1ns/10ps

interface id_ctrl_if import riscv_isa_pkg::*, id_ctrl_pkg::*;;

  // ALU and operand routing
  logic      alu_en;
  alu_op_e   alu_op;
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  op_c_sel_e op_c_sel;
  imm_sel_e  imm_sel;

  // Load/store
  logic      lsu_en;
  logic      lsu_we;
  lsu_size_e lsu_size;
  logic      lsu_sext;

  // Writeback, control flow and exception
  logic      rf_we;
  logic      jmp;
  logic      jmpr;
  logic      bch;
  logic      illegal;

  modport decoder (output alu_en, alu_op, op_a_sel, op_b_sel, op_c_sel, imm_sel,
                   lsu_en, lsu_we, lsu_size, lsu_sext, rf_we, jmp, jmpr, bch, illegal);

  modport consumer (input alu_en, alu_op, op_a_sel, op_b_sel, op_c_sel, imm_sel,
                    lsu_en, lsu_we, lsu_size, lsu_sext, rf_we, jmp, jmpr, bch, illegal);

endinterface

// File: design/id_decoder.sv
// RV32I opcode/funct decoder; drives the control bundle and flags illegal encodings
`timescale 1ns/10ps

module id_decoder import riscv_isa_pkg::*, id_ctrl_pkg::*; (
  input  word_t      instr_i,
  id_ctrl_if.decoder ctrl_o
);

  opcode_e   opcode;
  logic [2:0] funct3;
  logic       bit30;
  reg_addr_t  rd;

  // Register-register and immediate ALU ops share the funct3 mapping
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[FUNCT3_MSB:FUNCT3_LSB];
  assign bit30  = instr_i[FUNCT7_BIT30];
  assign rd     = instr_i[RD_MSB:RD_LSB];

  always_comb begin
    // Defaults describe a bubble
    ctrl_o.alu_en   = 1'b0;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.op_a_sel = OPA_NONE;
    ctrl_o.op_b_sel = OPB_NONE;
    ctrl_o.op_c_sel = OPC_NONE;
    ctrl_o.imm_sel  = IMM_I;
    ctrl_o.lsu_en   = 1'b0;
    ctrl_o.lsu_we   = 1'b0;
    ctrl_o.lsu_size = LSU_WORD;
    ctrl_o.lsu_sext = 1'b0;
    ctrl_o.rf_we    = 1'b0;
    ctrl_o.jmp      = 1'b0;
    ctrl_o.jmpr     = 1'b0;
    ctrl_o.bch      = 1'b0;
    ctrl_o.illegal  = 1'b0;

    case (opcode)
      OPC_OP: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.alu_op   = alu_from_funct3(funct3, bit30);
        ctrl_o.op_a_sel = OPA_REG;
        ctrl_o.op_b_sel = OPB_REG;
        ctrl_o.rf_we    = 1'b1;
        // funct7 may only be 0, or 0x20 for SUB and SRA
        if ({instr_i[31], instr_i[29:25]} != 6'b0 ||
            (bit30 && funct3 != 3'b000 && funct3 != 3'b101)) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        ctrl_o.alu_en   = 1'b1;
        // Bit 30 is immediate data except for the right shifts
        ctrl_o.alu_op   = alu_from_funct3(funct3, bit30 && funct3 == 3'b101);
        ctrl_o.op_a_sel = OPA_REG;
        ctrl_o.op_b_sel = OPB_IMM;
        ctrl_o.rf_we    = 1'b1;
        if ((funct3 == 3'b001 && instr_i[31:25] != 7'b0) ||
            (funct3 == 3'b101 && {instr_i[31], instr_i[29:25]} != 6'b0)) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.op_a_sel = (opcode == OPC_LUI) ? OPA_ZERO : OPA_PC;
        ctrl_o.op_b_sel = OPB_IMM;
        ctrl_o.imm_sel  = IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        // Link value pc+4 is computed by the ALU
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.op_a_sel = OPA_PC;
        ctrl_o.op_b_sel = OPB_PCINCR;
        ctrl_o.imm_sel  = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.jmp      = 1'b1;
        ctrl_o.jmpr     = (opcode == OPC_JALR);
        if (opcode == OPC_JALR && funct3 != 3'b000) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPC_BRANCH: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.op_a_sel = OPA_REG;
        ctrl_o.op_b_sel = OPB_REG;
        ctrl_o.op_c_sel = OPC_BCH;
        ctrl_o.imm_sel  = IMM_B;
        ctrl_o.bch      = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // Address is rs1 + I immediate
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.op_a_sel = OPA_REG;
        ctrl_o.op_b_sel = OPB_IMM;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.lsu_sext = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: ctrl_o.lsu_size = LSU_BYTE;
          3'b001, 3'b101: ctrl_o.lsu_size = LSU_HALF;
          3'b010:         ctrl_o.lsu_size = LSU_WORD;
          default:        ctrl_o.illegal  = 1'b1;
        endcase
      end
      OPC_STORE: begin
        // Store data travels on operand C
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.op_a_sel = OPA_REG;
        ctrl_o.op_b_sel = OPB_IMM;
        ctrl_o.op_c_sel = OPC_REG;
        ctrl_o.imm_sel  = IMM_S;
        case (funct3)
          3'b000:  ctrl_o.lsu_size = LSU_BYTE;
          3'b001:  ctrl_o.lsu_size = LSU_HALF;
          3'b010:  ctrl_o.lsu_size = LSU_WORD;
          default: ctrl_o.illegal  = 1'b1;
        endcase
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal instructions must not write, access memory or redirect
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we  = 1'b0;
      ctrl_o.lsu_en = 1'b0;
      ctrl_o.alu_en = 1'b0;
      ctrl_o.jmp    = 1'b0;
      ctrl_o.jmpr   = 1'b0;
      ctrl_o.bch    = 1'b0;
    end

    // x0 is hardwired to zero
    if (rd == 5'd0) begin
      ctrl_o.rf_we = 1'b0;
    end
  end

endmodule

// File: design/id_operand_mux.sv
// Immediate generation, EX/WB forwarding and operand A/B/C selection for the ID/EX register
`timescale 1ns/10ps

module id_operand_mux import riscv_isa_pkg::*, id_ctrl_pkg::*; (
  input  word_t       instr_i,
  input  word_t       pc_i,
  input  word_t       rf_rdata_a_i,
  input  word_t       rf_rdata_b_i,
  input  word_t       ex_fwd_i,
  input  word_t       wb_fwd_i,
  input  fwd_sel_e    fwd_sel_a_i,
  input  fwd_sel_e    fwd_sel_b_i,
  input  word_t       bch_target_i,
  id_ctrl_if.consumer ctrl_i,
  output word_t       fwd_a_o,
  output word_t       operand_a_o,
  output word_t       operand_b_o,
  output word_t       operand_c_o
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t imm;
  word_t fwd_a;
  word_t fwd_b;

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////////////////////

  // Sign bit is always instr[31]
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    case (ctrl_i.imm_sel)
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (fwd_sel_a_i)
      FWD_EX:  fwd_a = ex_fwd_i;
      FWD_WB:  fwd_a = wb_fwd_i;
      default: fwd_a = rf_rdata_a_i;
    endcase
    case (fwd_sel_b_i)
      FWD_EX:  fwd_b = ex_fwd_i;
      FWD_WB:  fwd_b = wb_fwd_i;
      default: fwd_b = rf_rdata_b_i;
    endcase
  end

  // Forwarded rs1 also feeds the JALR target adder
  assign fwd_a_o = fwd_a;

  ////////////////////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.op_a_sel)
      OPA_PC:   operand_a_o = pc_i;
      OPA_ZERO: operand_a_o = '0;
      default:  operand_a_o = fwd_a;
    endcase
    case (ctrl_i.op_b_sel)
      OPB_IMM:    operand_b_o = imm;
      // Link offset, no compressed instructions
      OPB_PCINCR: operand_b_o = 32'd4;
      default:    operand_b_o = fwd_b;
    endcase
    // Store data, or the branch target for EX to redirect on
    operand_c_o = (ctrl_i.op_c_sel == OPC_BCH) ? bch_target_i : fwd_b;
  end

endmodule

// File: design/id_jump_target.sv
// Jump and branch target adders; jump target leaves the stage in the decode cycle
`timescale 1ns/10ps

module id_jump_target import riscv_isa_pkg::*; (
  input  word_t       instr_i,
  input  word_t       pc_i,
  input  word_t       fwd_a_i,
  id_ctrl_if.consumer ctrl_i,
  output word_t       jmp_target_o,
  output word_t       bch_target_o
);

  word_t imm_i;
  word_t imm_j;
  word_t imm_b;
  word_t jalr_sum;

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  // JALR uses forwarded rs1, LSB forced to zero
  assign jalr_sum     = fwd_a_i + imm_i;
  assign jmp_target_o = ctrl_i.jmpr ? {jalr_sum[xlen-1:1], 1'b0} : pc_i + imm_j;

  // Taken-branch target, resolved in EX
  assign bch_target_o = pc_i + imm_b;

endmodule

// File: design/id_ex_pipe.sv
// ID/EX pipeline register with valid/ready handshake, kill and halt; gates unused fields
`timescale 1ns/10ps

module id_ex_pipe import riscv_isa_pkg::*, id_ctrl_pkg::*; #(
  parameter bit GATE_UNUSED = 1'b1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic        kill_i,
  input  logic        halt_i,
  input  logic        ex_ready_i,
  id_ctrl_if.consumer ctrl_i,
  input  word_t       instr_i,
  input  word_t       pc_i,
  input  word_t       operand_a_i,
  input  word_t       operand_b_i,
  input  word_t       operand_c_i,
  output logic        id_ready_o,
  output logic        ex_valid_o,
  output logic        ex_alu_en_o,
  output alu_op_e     ex_alu_op_o,
  output word_t       ex_operand_a_o,
  output word_t       ex_operand_b_o,
  output word_t       ex_operand_c_o,
  output word_t       ex_pc_o,
  output logic        ex_lsu_en_o,
  output logic        ex_lsu_we_o,
  output lsu_size_e   ex_lsu_size_o,
  output logic        ex_lsu_sext_o,
  output logic        ex_rf_we_o,
  output reg_addr_t   ex_rf_waddr_o,
  output logic        ex_illegal_o
);

  logic load_ok;
  logic xfer;

  // Register free when EX takes its entry or holds none
  assign load_ok    = ex_ready_i || !ex_valid_o;
  // Kill always drains decode
  assign id_ready_o = kill_i || (!halt_i && load_ok);
  assign xfer       = instr_valid_i && !kill_i && !halt_i && load_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Control fields
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o   <= 1'b0;
      ex_alu_en_o  <= 1'b0;
      ex_lsu_en_o  <= 1'b0;
      ex_rf_we_o   <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else if (xfer) begin
      ex_valid_o   <= 1'b1;
      ex_alu_en_o  <= ctrl_i.alu_en;
      ex_lsu_en_o  <= ctrl_i.lsu_en;
      ex_rf_we_o   <= ctrl_i.rf_we;
      ex_illegal_o <= ctrl_i.illegal;
    end else if (load_ok) begin
      // Bubble into EX
      ex_valid_o   <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload fields, loaded only when the instruction uses them
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (xfer) begin
      ex_pc_o <= pc_i;
      if (!GATE_UNUSED || ctrl_i.alu_en) begin
        ex_alu_op_o <= ctrl_i.alu_op;
      end
      if (!GATE_UNUSED || ctrl_i.op_a_sel != OPA_NONE) begin
        ex_operand_a_o <= operand_a_i;
      end
      if (!GATE_UNUSED || ctrl_i.op_b_sel != OPB_NONE) begin
        ex_operand_b_o <= operand_b_i;
      end
      if (!GATE_UNUSED || ctrl_i.op_c_sel != OPC_NONE) begin
        ex_operand_c_o <= operand_c_i;
      end
      if (!GATE_UNUSED || ctrl_i.lsu_en) begin
        ex_lsu_we_o   <= ctrl_i.lsu_we;
        ex_lsu_size_o <= ctrl_i.lsu_size;
        ex_lsu_sext_o <= ctrl_i.lsu_sext;
      end
      if (!GATE_UNUSED || ctrl_i.rf_we) begin
        ex_rf_waddr_o <= instr_i[RD_MSB:RD_LSB];
      end
    end
  end

endmodule

// File: design/id_stage.sv
// Decode stage top level; instantiate with plain ports between IF and EX of the core
`timescale 1ns/10ps

module id_stage import riscv_isa_pkg::*, id_ctrl_pkg::*; #(
  parameter bit GATE_UNUSED = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  // From IF
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  input  word_t     pc_i,
  output logic      id_ready_o,
  // From the controller
  input  logic      kill_i,
  input  logic      halt_i,
  // Register file and forwarding
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  input  word_t     ex_fwd_i,
  input  word_t     wb_fwd_i,
  input  fwd_sel_e  fwd_sel_a_i,
  input  fwd_sel_e  fwd_sel_b_i,
  // Jump redirect to IF
  output word_t     jmp_target_o,
  // To EX
  input  logic      ex_ready_i,
  output logic      ex_valid_o,
  output logic      ex_alu_en_o,
  output alu_op_e   ex_alu_op_o,
  output word_t     ex_operand_a_o,
  output word_t     ex_operand_b_o,
  output word_t     ex_operand_c_o,
  output word_t     ex_pc_o,
  output logic      ex_lsu_en_o,
  output logic      ex_lsu_we_o,
  output lsu_size_e ex_lsu_size_o,
  output logic      ex_lsu_sext_o,
  output logic      ex_rf_we_o,
  output reg_addr_t ex_rf_waddr_o,
  output logic      ex_illegal_o
);

  word_t fwd_a;
  word_t bch_target;
  word_t operand_a;
  word_t operand_b;
  word_t operand_c;

  id_ctrl_if ctrl_if ();

  // Source registers read straight from the instruction
  assign rf_raddr_a_o = instr_i[RS1_MSB:RS1_LSB];
  assign rf_raddr_b_o = instr_i[RS2_MSB:RS2_LSB];

  id_decoder u_decoder (
    .instr_i (instr_i),
    .ctrl_o  (ctrl_if.decoder)
  );

  id_jump_target u_jump_target (
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .fwd_a_i      (fwd_a),
    .ctrl_i       (ctrl_if.consumer),
    .jmp_target_o (jmp_target_o),
    .bch_target_o (bch_target)
  );

  id_operand_mux u_operand_mux (
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .ex_fwd_i     (ex_fwd_i),
    .wb_fwd_i     (wb_fwd_i),
    .fwd_sel_a_i  (fwd_sel_a_i),
    .fwd_sel_b_i  (fwd_sel_b_i),
    .bch_target_i (bch_target),
    .ctrl_i       (ctrl_if.consumer),
    .fwd_a_o      (fwd_a),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c)
  );

  id_ex_pipe #(
    .GATE_UNUSED (GATE_UNUSED)
  ) u_id_ex_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .ex_ready_i     (ex_ready_i),
    .ctrl_i         (ctrl_if.consumer),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .operand_c_i    (operand_c),
    .id_ready_o     (id_ready_o),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_en_o    (ex_alu_en_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_pc_o        (ex_pc_o),
    .ex_lsu_en_o    (ex_lsu_en_o),
    .ex_lsu_we_o    (ex_lsu_we_o),
    .ex_lsu_size_o  (ex_lsu_size_o),
    .ex_lsu_sext_o  (ex_lsu_sext_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_rf_waddr_o  (ex_rf_waddr_o),
    .ex_illegal_o   (ex_illegal_o)
  );

endmodule

// File: verif/id_stage_tb.sv
// Self-checking table-driven testbench for the decode stage; built and run by the Makefile
`timescale 1ns/10ps

module id_stage_tb import riscv_isa_pkg::*, id_ctrl_pkg::*; ();

  logic      clk;
  logic      rst_n;
  logic      instr_valid_i;
  word_t     instr_i;
  word_t     pc_i;
  logic      id_ready_o;
  logic      kill_i;
  logic      halt_i;
  reg_addr_t rf_raddr_a_o;
  reg_addr_t rf_raddr_b_o;
  word_t     rf_rdata_a_i;
  word_t     rf_rdata_b_i;
  word_t     ex_fwd_i;
  word_t     wb_fwd_i;
  fwd_sel_e  fwd_sel_a_i;
  fwd_sel_e  fwd_sel_b_i;
  word_t     jmp_target_o;
  logic      ex_ready_i;
  logic      ex_valid_o;
  logic      ex_alu_en_o;
  alu_op_e   ex_alu_op_o;
  word_t     ex_operand_a_o;
  word_t     ex_operand_b_o;
  word_t     ex_operand_c_o;
  word_t     ex_pc_o;
  logic      ex_lsu_en_o;
  logic      ex_lsu_we_o;
  lsu_size_e ex_lsu_size_o;
  logic      ex_lsu_sext_o;
  logic      ex_rf_we_o;
  reg_addr_t ex_rf_waddr_o;
  logic      ex_illegal_o;

  // One stimulus row with its expected ID/EX contents
  typedef struct packed {
    word_t      instr;
    word_t      pc;
    word_t      rdata_a;
    word_t      rdata_b;
    fwd_sel_e   sel_a;
    fwd_sel_e   sel_b;
    word_t      ex_data;
    word_t      wb_data;
    logic       alu_en;
    alu_op_e    alu_op;
    // Operands A, B and C in use with A in the MSB
    logic [2:0] use_abc;
    word_t      op_a;
    word_t      op_b;
    word_t      op_c;
    logic       use_jmp;
    word_t      jmp_target;
    // Load/store enable, write and sign extension
    logic [2:0] lsu;
    lsu_size_e  lsu_size;
    logic       rf_we;
    reg_addr_t  waddr;
    logic       illegal;
  } entry_t;

  entry_t tbl[$];
  integer seed;
  word_t  ra;
  word_t  rb;
  word_t  exd;
  word_t  wbd;

  id_stage #(
    .GATE_UNUSED (1'b1)
  ) u_id_stage (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare and wait helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_fail();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, act, exp);
      report_fail();
    end
  endtask

  task automatic check_alu_op(input string name, input alu_op_e act, input alu_op_e exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s = %s, expected %s", $time, name, act.name(), exp.name());
      report_fail();
    end
  endtask

  task automatic check_size(input string name, input lsu_size_e act, input lsu_size_e exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s = %s, expected %s", $time, name, act.name(), exp.name());
      report_fail();
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s = %b, expected %b", $time, name, act, exp);
      report_fail();
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout: no %s within 20 cycles at %0t", what, $time);
    report_fail();
  endtask

  // Called at a falling edge; returns at the falling edge before acceptance
  task automatic wait_ready();
    int n;
    n = 0;
    while (!id_ready_o) begin
      n++;
      if (n > 20) timed_out("id_ready_o");
      @(negedge clk);
    end
  endtask

  task automatic wait_valid(output int n);
    n = 0;
    @(negedge clk);
    while (!ex_valid_o) begin
      n++;
      if (n > 20) timed_out("ex_valid_o");
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checking of one entry
  ////////////////////////////////////////////////////////////////////////////

  task automatic new_data();
    ra  = $random(seed);
    rb  = $random(seed);
    exd = $random(seed);
    wbd = $random(seed);
  endtask

  task automatic add_entry(input word_t instr, input word_t pc, input fwd_sel_e sel_a,
                           input fwd_sel_e sel_b, input logic alu_en, input alu_op_e alu_op,
                           input logic [2:0] use_abc, input word_t op_a, input word_t op_b,
                           input word_t op_c, input logic use_jmp, input word_t jmp_target,
                           input logic [2:0] lsu, input lsu_size_e lsu_size,
                           input logic rf_we, input reg_addr_t waddr, input logic illegal);
    entry_t e;
    e = '{instr, pc, ra, rb, sel_a, sel_b, exd, wbd, alu_en, alu_op, use_abc, op_a, op_b,
          op_c, use_jmp, jmp_target, lsu, lsu_size, rf_we, waddr, illegal};
    tbl.push_back(e);
  endtask

  task automatic drive_entry(input entry_t e);
    instr_i       = e.instr;
    pc_i          = e.pc;
    rf_rdata_a_i  = e.rdata_a;
    rf_rdata_b_i  = e.rdata_b;
    fwd_sel_a_i   = e.sel_a;
    fwd_sel_b_i   = e.sel_b;
    ex_fwd_i      = e.ex_data;
    wb_fwd_i      = e.wb_data;
    instr_valid_i = 1'b1;
  endtask

  // Fields that the instruction leaves unused are not compared
  task automatic check_outputs(input entry_t e);
    check_bit("ex_alu_en_o", ex_alu_en_o, e.alu_en);
    if (e.alu_en) check_alu_op("ex_alu_op_o", ex_alu_op_o, e.alu_op);
    if (e.use_abc[2]) check_word("ex_operand_a_o", ex_operand_a_o, e.op_a);
    if (e.use_abc[1]) check_word("ex_operand_b_o", ex_operand_b_o, e.op_b);
    if (e.use_abc[0]) check_word("ex_operand_c_o", ex_operand_c_o, e.op_c);
    check_word("ex_pc_o", ex_pc_o, e.pc);
    check_bit("ex_lsu_en_o", ex_lsu_en_o, e.lsu[2]);
    if (e.lsu[2]) begin
      check_bit("ex_lsu_we_o", ex_lsu_we_o, e.lsu[1]);
      check_size("ex_lsu_size_o", ex_lsu_size_o, e.lsu_size);
      check_bit("ex_lsu_sext_o", ex_lsu_sext_o, e.lsu[0]);
    end
    check_bit("ex_rf_we_o", ex_rf_we_o, e.rf_we);
    if (e.rf_we) check_word("ex_rf_waddr_o", {27'b0, ex_rf_waddr_o}, {27'b0, e.waddr});
    check_bit("ex_illegal_o", ex_illegal_o, e.illegal);
  endtask

  task automatic accept_and_check(input entry_t e);
    int n;
    wait_ready();
    // Transfer happens on this edge
    @(posedge clk);
    #2;
    instr_valid_i = 1'b0;
    wait_valid(n);
    check_bit("ex_valid_o one cycle after acceptance", n == 0, 1'b1);
    check_outputs(e);
  endtask

  task automatic apply_entry(input entry_t e);
    @(posedge clk);
    #2;
    drive_entry(e);
    @(negedge clk);
    // Combinational outputs in the decode cycle
    check_word("rf_raddr_a_o", {27'b0, rf_raddr_a_o}, {27'b0, e.instr[19:15]});
    check_word("rf_raddr_b_o", {27'b0, rf_raddr_b_o}, {27'b0, e.instr[24:20]});
    if (e.use_jmp) check_word("jmp_target_o", jmp_target_o, e.jmp_target);
    accept_and_check(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    rf_rdata_a_i  = '0;
    rf_rdata_b_i  = '0;
    ex_fwd_i      = '0;
    wb_fwd_i      = '0;
    fwd_sel_a_i   = FWD_RF;
    fwd_sel_b_i   = FWD_RF;
    ex_ready_i    = 1'b1;
    seed          = 1886;

    new_data();
    // ADD x3, x1, x2
    add_entry(32'h002081B3, 32'h100, FWD_RF, FWD_RF, 1'b1, ALU_ADD, 3'b110, ra, rb, '0,
              1'b0, '0, 3'b000, LSU_WORD, 1'b1, 5'd3, 1'b0);
    // SUB x5, x6, x7 with rs1 from EX and rs2 from WB
    add_entry(32'h407302B3, 32'h104, FWD_EX, FWD_WB, 1'b1, ALU_SUB, 3'b110, exd, wbd, '0,
              1'b0, '0, 3'b000, LSU_WORD, 1'b1, 5'd5, 1'b0);
    // ADDI x4, x1, -5
    add_entry(32'hFFB08213, 32'h108, FWD_RF, FWD_RF, 1'b1, ALU_ADD, 3'b110, ra, 32'hFFFFFFFB,
              '0, 1'b0, '0, 3'b000, LSU_WORD, 1'b1, 5'd4, 1'b0);
    // SRAI x9, x2, 3 with rs1 from WB
    add_entry(32'h40315493, 32'h10C, FWD_WB, FWD_RF, 1'b1, ALU_SRA, 3'b110, wbd, 32'h403,
              '0, 1'b0, '0, 3'b000, LSU_WORD, 1'b1, 5'd9, 1'b0);
    new_data();
    // SLTIU x10, x3, 0x7ff
    add_entry(32'h7FF1B513, 32'h110, FWD_RF, FWD_RF, 1'b1, ALU_SLTU, 3'b110, ra, 32'h7FF,
              '0, 1'b0, '0, 3'b000, LSU_WORD, 1'b1, 5'd10, 1'b0);
    // AND x8, x1, x2
    add_entry(32'h0020F433, 32'h114, FWD_RF, FWD_RF, 1'b1, ALU_AND, 3'b110, ra, rb, '0,
              1'b0, '0, 3'b000, LSU_WORD, 1'b1, 5'd8, 1'b0);
    // LUI x11 and AUIPC x12
    add_entry(32'hABCDE5B7, 32'h118, FWD_RF, FWD_RF, 1'b1, ALU_ADD, 3'b110, '0, 32'hABCDE000,
              '0, 1'b0, '0, 3'b000, LSU_WORD, 1'b1, 5'd11, 1'b0);
    add_entry(32'h12345617, 32'h1000, FWD_RF, FWD_RF, 1'b1, ALU_ADD, 3'b110, 32'h1000,
              32'h12345000, '0, 1'b0, '0, 3'b000, LSU_WORD, 1'b1, 5'd12, 1'b0);
    new_data();
    // LW x13, -4(x2), LBU x14, 8(x1) from WB, LH x15, 2(x1)
    add_entry(32'hFFC12683, 32'h1004, FWD_RF, FWD_RF, 1'b0, ALU_ADD, 3'b110, ra, 32'hFFFFFFFC,
              '0, 1'b0, '0, 3'b101, LSU_WORD, 1'b1, 5'd13, 1'b0);
    add_entry(32'h0080C703, 32'h1008, FWD_WB, FWD_RF, 1'b0, ALU_ADD, 3'b110, wbd, 32'h8,
              '0, 1'b0, '0, 3'b100, LSU_BYTE, 1'b1, 5'd14, 1'b0);
    add_entry(32'h00209783, 32'h100C, FWD_RF, FWD_RF, 1'b0, ALU_ADD, 3'b110, ra, 32'h2,
              '0, 1'b0, '0, 3'b101, LSU_HALF, 1'b1, 5'd15, 1'b0);
    // SW x7, 20(x5) with store data from EX, SB x2, -1(x1)
    add_entry(32'h0072AA23, 32'h1010, FWD_RF, FWD_EX, 1'b0, ALU_ADD, 3'b111, ra, 32'd20,
              exd, 1'b0, '0, 3'b110, LSU_WORD, 1'b0, 5'd0, 1'b0);
    add_entry(32'hFE208FA3, 32'h1014, FWD_RF, FWD_RF, 1'b0, ALU_ADD, 3'b111, ra, 32'hFFFFFFFF,
              rb, 1'b0, '0, 3'b110, LSU_BYTE, 1'b0, 5'd0, 1'b0);
    new_data();
    // JAL x1, +2048, and JAL x0, -16 which must not write
    add_entry(32'h001000EF, 32'h2000, FWD_RF, FWD_RF, 1'b1, ALU_ADD, 3'b110, 32'h2000, 32'd4,
              '0, 1'b1, 32'h2800, 3'b000, LSU_WORD, 1'b1, 5'd1, 1'b0);
    add_entry(32'hFF1FF06F, 32'h3000, FWD_RF, FWD_RF, 1'b1, ALU_ADD, 3'b110, 32'h3000, 32'd4,
              '0, 1'b1, 32'h2FF0, 3'b000, LSU_WORD, 1'b0, 5'd0, 1'b0);
    // JALR x5, 12(x6) from EX, JALR x1, -4(x2) from WB, both with the target LSB cleared
    add_entry(32'h00C302E7, 32'h3100, FWD_EX, FWD_RF, 1'b1, ALU_ADD, 3'b110, 32'h3100, 32'd4,
              '0, 1'b1, (exd + 32'd12) & 32'hFFFFFFFE, 3'b000, LSU_WORD, 1'b1, 5'd5, 1'b0);
    add_entry(32'hFFC100E7, 32'h3200, FWD_WB, FWD_RF, 1'b1, ALU_ADD, 3'b110, 32'h3200, 32'd4,
              '0, 1'b1, (wbd + 32'hFFFFFFFC) & 32'hFFFFFFFE, 3'b000, LSU_WORD, 1'b1, 5'd1,
              1'b0);
    // BNE x1, x2, -8 and BGEU x3, x4, +16 with forwarded sources
    add_entry(32'hFE209CE3, 32'h4000, FWD_RF, FWD_RF, 1'b1, ALU_NE, 3'b111, ra, rb,
              32'h3FF8, 1'b0, '0, 3'b000, LSU_WORD, 1'b0, 5'd0, 1'b0);
    add_entry(32'h0041F863, 32'h5000, FWD_EX, FWD_WB, 1'b1, ALU_GEU, 3'b111, exd, wbd,
              32'h5010, 1'b0, '0, 3'b000, LSU_WORD, 1'b0, 5'd0, 1'b0);
    // Unknown opcode 0x7f
    add_entry(32'h00000FFF, 32'h6000, FWD_RF, FWD_RF, 1'b0, ALU_ADD, 3'b000, '0, '0, '0,
              1'b0, '0, 3'b000, LSU_WORD, 1'b0, 5'd0, 1'b1);

    // Reset held for 4 cycles with the cleared state checked mid-reset
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("ex_rf_we_o", ex_rf_we_o, 1'b0);
    check_bit("ex_lsu_en_o", ex_lsu_en_o, 1'b0);
    check_bit("ex_alu_en_o", ex_alu_en_o, 1'b0);
    @(posedge clk);
    #2;
    rst_n = 1'b1;

    foreach (tbl[i]) apply_entry(tbl[i]);

    // Back-pressure with one entry in EX and the next waiting in decode
    @(posedge clk);
    #2;
    ex_ready_i = 1'b0;
    drive_entry(tbl[2]);
    @(negedge clk);
    accept_and_check(tbl[2]);
    @(posedge clk);
    #2;
    drive_entry(tbl[3]);
    repeat (3) begin
      @(negedge clk);
      check_bit("id_ready_o", id_ready_o, 1'b0);
      check_outputs(tbl[2]);
    end
    @(posedge clk);
    #2;
    ex_ready_i = 1'b1;
    @(negedge clk);
    accept_and_check(tbl[3]);

    // Halt blocks the transfer
    @(posedge clk);
    #2;
    halt_i = 1'b1;
    drive_entry(tbl[0]);
    repeat (3) begin
      @(negedge clk);
      check_bit("id_ready_o", id_ready_o, 1'b0);
      check_bit("ex_valid_o", ex_valid_o, 1'b0);
    end
    @(posedge clk);
    #2;
    halt_i = 1'b0;
    @(negedge clk);
    accept_and_check(tbl[0]);

    // Kill drains decode even while halted
    @(posedge clk);
    #2;
    kill_i = 1'b1;
    halt_i = 1'b1;
    drive_entry(tbl[1]);
    @(negedge clk);
    check_bit("id_ready_o", id_ready_o, 1'b1);
    // Without halt the killed instruction still leaves EX empty
    @(posedge clk);
    #2;
    halt_i = 1'b0;
    @(negedge clk);
    check_bit("id_ready_o", id_ready_o, 1'b1);
    @(negedge clk);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    @(posedge clk);
    #2;
    kill_i        = 1'b0;
    instr_valid_i = 1'b0;

    // Asynchronous reset clears a load held in EX by back-pressure
    ex_ready_i = 1'b0;
    drive_entry(tbl[8]);
    @(negedge clk);
    accept_and_check(tbl[8]);
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    @(negedge clk);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("ex_rf_we_o", ex_rf_we_o, 1'b0);
    check_bit("ex_lsu_en_o", ex_lsu_en_o, 1'b0);
    check_bit("ex_alu_en_o", ex_alu_en_o, 1'b0);
    @(posedge clk);
    #2;
    rst_n      = 1'b1;
    ex_ready_i = 1'b1;

    $display("** PASS **");
    $finish;
  end

endmodule

// File: sim.f
design/riscv_isa_pkg.sv
design/id_ctrl_pkg.sv
design/id_ctrl_if.sv
design/id_decoder.sv
design/id_operand_mux.sv
design/id_jump_target.sv
design/id_ex_pipe.sv
design/id_stage.sv
verif/id_stage_tb.sv

// File: Makefile
BIN := obj_dir/Vid_stage_tb

.PHONY: all lint clean

all: $(BIN)
	./$(BIN) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

$(BIN): sim.f design/*.sv verif/*.sv
	verilator --binary --timing --timescale 1ns/10ps --top-module id_stage_tb -f sim.f

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps --top-module id_stage -f sim.f

clean:
	rm -rf obj_dir sim.log
